/* Makefile */
# Verilator build and run of the manycore link to FSB testbench

VERILATOR ?= verilator
TOP       ?= tb_links_to_fsb
FILELIST  ?= manycore_links_to_fsb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/fsb_frame_out.sv */
// registered FSB output stage that frames tunnel words, valid/yumi toward the ring
`timescale 1ns/10ps

module fsb_frame_out
   import fsb_tunnel_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_i,
   input  logic         word_v_i,
   input  tunnel_word_s word_i,
   output logic         word_ready_o,
   output logic         v_o,
   output fsb_frame_s   data_o,
   input  logic         yumi_i
);

   fsb_frame_s frame_r;
   logic       v_r;
   logic       accept;

   // empty, or emptied by yumi this cycle
   assign word_ready_o = ~v_r | yumi_i;
   assign accept       = word_v_i & word_ready_o;

   assign v_o    = v_r;
   assign data_o = frame_r;

   // tunnel word sits in the low bits, client command
   always_ff @(posedge clk_i)
   begin
      if (accept)
         frame_r <= '{destid: DEST_ID, cmd: 1'b0, data: FSB_DATA_WIDTH'(word_i)};
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         v_r <= 1'b0;
      else if (accept)
         v_r <= 1'b1;
      else if (yumi_i)
         v_r <= 1'b0;
   end

endmodule

/* logic/fsb_tunnel_pkg.sv */
// FSB frame struct, tunnel tag and payload union, credit and buffer constants
package fsb_tunnel_pkg;

   import mc_link_pkg::*;

   // FSB ring word and client frame layout
   localparam int RING_WIDTH = 80;
   localparam int FSB_ID_WIDTH = 4;
   localparam int FSB_DATA_WIDTH = RING_WIDTH - FSB_ID_WIDTH - 1;
   localparam logic [FSB_ID_WIDTH-1:0] DEST_ID = 4'h3;

   // receive buffer depth per channel, also the starting credit count
   localparam int REMOTE_CREDITS = 4;
   // pending count that asks for a credit word
   localparam int CREDIT_BATCH = 2;
   localparam int CREDIT_WIDTH = 3;
   localparam int BUF_PTR_WIDTH = $clog2(REMOTE_CREDITS);

   // request packet is the wider of the two
   localparam int PAYLOAD_WIDTH = $bits(mc_packet_s);

   // tags 0..3 select a channel, tag 4 marks a credit word
   localparam int TAG_WIDTH = 3;
   localparam logic [TAG_WIDTH-1:0] CREDIT_TAG = 3'd4;

   // return packet padded up to payload width
   typedef struct packed {
      logic [PAYLOAD_WIDTH-$bits(mc_return_packet_s)-1:0] pad;
      mc_return_packet_s                                  pkt;
   } tunnel_ret_s;

   // one returned-credit count per channel
   typedef struct packed {
      logic [PAYLOAD_WIDTH-NUM_CHAN*CREDIT_WIDTH-1:0] pad;
      logic [NUM_CHAN-1:0][CREDIT_WIDTH-1:0]          count;
   } tunnel_credit_s;

   // the tag picks which view is meaningful
   typedef union packed {
      mc_packet_s     req;
      tunnel_ret_s    ret;
      tunnel_credit_s credit;
   } tunnel_payload_u;

   // 70 bits on the ring, in the low bits of the frame data
   typedef struct packed {
      logic [TAG_WIDTH-1:0] tag;
      tunnel_payload_u      payload;
   } tunnel_word_s;

   typedef struct packed {
      logic [FSB_ID_WIDTH-1:0]   destid;
      logic                      cmd;
      logic [FSB_DATA_WIDTH-1:0] data;
   } fsb_frame_s;

endpackage

/* logic/manycore_links_to_fsb.sv */
// top joining manycore link FIFOs, tunnel decode, channel arbiter and FSB framer
`timescale 1ns/10ps

module manycore_links_to_fsb
   import mc_link_pkg::*;
   import fsb_tunnel_pkg::*;
(
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  mc_link_in_s [NUM_LINKS-1:0]    links_i,
   output mc_link_out_s [NUM_LINKS-1:0]   links_o,
   input  logic                           v_i,
   input  logic [RING_WIDTH-1:0]          data_i,
   output logic                           ready_o,
   output logic                           v_o,
   output fsb_frame_s                     data_o,
   input  logic                           yumi_i
);

   // channel side toward the arbiter
   logic [NUM_CHAN-1:0]                   chan_v, chan_yumi;
   tunnel_payload_u [NUM_CHAN-1:0]        chan_payload;
   // channel side out of the decoder
   logic [NUM_CHAN-1:0]                   dec_v, dec_ready;
   tunnel_payload_u [NUM_CHAN-1:0]        dec_payload;
   logic [NUM_CHAN-1:0][CREDIT_WIDTH-1:0] credits_returned, pending_credits;
   logic                                  credit_req, credit_sent;
   tunnel_word_s                          tx_word, rx_word;
   logic                                  tx_word_v, tx_word_ready;

   // useful ring data is in the low bits
   assign rx_word = data_i[0+:$bits(tunnel_word_s)];

   // channel 2i is link i fwd, 2i+1 is link i rev
   for (genvar i = 0; i < NUM_LINKS; i++)
   begin : g_link
      mc_packet_s        fwd_data;
      mc_return_packet_s rev_data;
      logic              fwd_ready, rev_ready;

      two_fifo #(.WIDTH($bits(mc_packet_s))) fwd_fifo (
         .clk_i  (clk_i),
         .rst_i  (rst_i),
         .v_i    (links_i[i].fwd.v),
         .data_i (links_i[i].fwd.packet),
         .ready_o(fwd_ready),
         .v_o    (chan_v[2*i]),
         .data_o (fwd_data),
         .yumi_i (chan_yumi[2*i])
      );

      two_fifo #(.WIDTH($bits(mc_return_packet_s))) rev_fifo (
         .clk_i  (clk_i),
         .rst_i  (rst_i),
         .v_i    (links_i[i].rev.v),
         .data_i (links_i[i].rev.packet),
         .ready_o(rev_ready),
         .v_o    (chan_v[2*i+1]),
         .data_o (rev_data),
         .yumi_i (chan_yumi[2*i+1])
      );

      // short return packet is zero padded
      assign chan_payload[2*i].req   = fwd_data;
      assign chan_payload[2*i+1].ret = '{pad: '0, pkt: rev_data};

      // manycore readiness drives the receive buffer dequeue
      assign dec_ready[2*i]   = links_i[i].fwd.ready_and_rev;
      assign dec_ready[2*i+1] = links_i[i].rev.ready_and_rev;

      assign links_o[i].fwd = '{v: dec_v[2*i], packet: dec_payload[2*i].req,
                                ready_and_rev: fwd_ready};
      assign links_o[i].rev = '{v: dec_v[2*i+1], packet: dec_payload[2*i+1].ret.pkt,
                                ready_and_rev: rev_ready};
   end

   tunnel_rx_decode rx_decode (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .v_i               (v_i),
      .data_i            (rx_word),
      .ready_o           (ready_o),
      .link_v_o          (dec_v),
      .link_payload_o    (dec_payload),
      .link_ready_i      (dec_ready),
      .credits_returned_o(credits_returned),
      .pending_credits_o (pending_credits),
      .credit_req_o      (credit_req),
      .credit_sent_i     (credit_sent)
   );

   tunnel_tx_arbiter tx_arbiter (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .chan_v_i          (chan_v),
      .chan_payload_i    (chan_payload),
      .chan_yumi_o       (chan_yumi),
      .credits_returned_i(credits_returned),
      .pending_credits_i (pending_credits),
      .credit_req_i      (credit_req),
      .credit_sent_o     (credit_sent),
      .word_v_o          (tx_word_v),
      .word_o            (tx_word),
      .word_ready_i      (tx_word_ready)
   );

   fsb_frame_out frame_out (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .word_v_i    (tx_word_v),
      .word_i      (tx_word),
      .word_ready_o(tx_word_ready),
      .v_o         (v_o),
      .data_o      (data_o),
      .yumi_i      (yumi_i)
   );

endmodule

/* logic/mc_link_pkg.sv */
// manycore link topology, field widths, packet structs and link bundle structs
package mc_link_pkg;

   // two links, each with a forward and a reverse net
   localparam int NUM_LINKS = 2;
   localparam int NUM_NETS = 2;
   localparam int NUM_CHAN = NUM_LINKS * NUM_NETS;
   localparam int CHAN_IDX_WIDTH = $clog2(NUM_CHAN);

   // packet field widths
   localparam int ADDR_WIDTH = 20;
   localparam int DATA_WIDTH = 32;
   localparam int LOAD_ID_WIDTH = 5;
   localparam int X_CORD_WIDTH = 2;
   localparam int Y_CORD_WIDTH = 2;

   // request on the forward net, 67 bits
   typedef struct packed {
      logic [1:0]               op;
      logic [ADDR_WIDTH-1:0]    addr;
      logic [DATA_WIDTH-1:0]    data;
      logic [LOAD_ID_WIDTH-1:0] load_id;
      logic [X_CORD_WIDTH-1:0]  src_x;
      logic [Y_CORD_WIDTH-1:0]  src_y;
      logic [X_CORD_WIDTH-1:0]  dest_x;
      logic [Y_CORD_WIDTH-1:0]  dest_y;
   } mc_packet_s;

   // return on the reverse net, 43 bits
   typedef struct packed {
      logic [1:0]               return_type;
      logic [DATA_WIDTH-1:0]    data;
      logic [LOAD_ID_WIDTH-1:0] load_id;
      logic [X_CORD_WIDTH-1:0]  dest_x;
      logic [Y_CORD_WIDTH-1:0]  dest_y;
   } mc_return_packet_s;

   // driven by the manycore, one bundle per net
   // ready_and_rev is readiness for traffic going toward the manycore
   typedef struct packed {
      logic       v;
      mc_packet_s packet;
      logic       ready_and_rev;
   } mc_fwd_in_s;

   typedef struct packed {
      logic              v;
      mc_return_packet_s packet;
      logic              ready_and_rev;
   } mc_rev_in_s;

   // driven toward the manycore
   typedef struct packed {
      logic       v;
      mc_packet_s packet;
      logic       ready_and_rev;
   } mc_fwd_out_s;

   typedef struct packed {
      logic              v;
      mc_return_packet_s packet;
      logic              ready_and_rev;
   } mc_rev_out_s;

   typedef struct packed {
      mc_fwd_in_s fwd;
      mc_rev_in_s rev;
   } mc_link_in_s;

   typedef struct packed {
      mc_fwd_out_s fwd;
      mc_rev_out_s rev;
   } mc_link_out_s;

endpackage

/* logic/tunnel_rx_decode.sv */
// inbound tunnel decode with input FIFO, per-channel receive buffers and credit counting
`timescale 1ns/10ps

module tunnel_rx_decode
   import mc_link_pkg::*;
   import fsb_tunnel_pkg::*;
(
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic                                  v_i,
   input  tunnel_word_s                          data_i,
   output logic                                  ready_o,
   output logic [NUM_CHAN-1:0]                   link_v_o,
   output tunnel_payload_u [NUM_CHAN-1:0]        link_payload_o,
   input  logic [NUM_CHAN-1:0]                   link_ready_i,
   output logic [NUM_CHAN-1:0][CREDIT_WIDTH-1:0] credits_returned_o,
   output logic [NUM_CHAN-1:0][CREDIT_WIDTH-1:0] pending_credits_o,
   output logic                                  credit_req_o,
   input  logic                                  credit_sent_i
);

   tunnel_word_s              word;
   logic                      word_v;
   logic                      pop;
   logic                      is_chan, is_credit;
   logic [CHAN_IDX_WIDTH-1:0] word_chan;
   logic [NUM_CHAN-1:0]       buf_full, enq, deq;

   // one cycle of slack on the ring side
   two_fifo #(.WIDTH($bits(tunnel_word_s))) in_fifo (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .v_i    (v_i),
      .data_i (data_i),
      .ready_o(ready_o),
      .v_o    (word_v),
      .data_o (word),
      .yumi_i (pop)
   );

   // tag decode
   assign is_chan   = word.tag < TAG_WIDTH'(NUM_CHAN);
   assign is_credit = word.tag == CREDIT_TAG;
   assign word_chan = word.tag[CHAN_IDX_WIDTH-1:0];

   // channel word waits for room; credit words never stall
   // buffer room is guaranteed by the sender's credits
   assign pop = word_v & (~is_chan | ~buf_full[word_chan]);

   // counts reach the arbiter in the pop cycle only
   assign credits_returned_o = (pop && is_credit) ? word.payload.credit.count : '0;

   for (genvar c = 0; c < NUM_CHAN; c++)
   begin : g_chan
      tunnel_payload_u [REMOTE_CREDITS-1:0] mem;
      logic [BUF_PTR_WIDTH-1:0]             wr_ptr, rd_ptr;
      logic [CREDIT_WIDTH-1:0]              count;
      logic [CREDIT_WIDTH-1:0]              pending;

      assign enq[c]      = pop & is_chan & (word_chan == CHAN_IDX_WIDTH'(c));
      // valid/ready toward the manycore
      assign deq[c]      = link_v_o[c] & link_ready_i[c];
      assign buf_full[c] = count == CREDIT_WIDTH'(REMOTE_CREDITS);

      assign link_v_o[c]          = count != '0;
      assign link_payload_o[c]    = mem[rd_ptr];
      assign pending_credits_o[c] = pending;

      // payload storage
      always_ff @(posedge clk_i)
      begin
         if (enq[c])
            mem[wr_ptr] <= word.payload;
      end

      always_ff @(posedge clk_i)
      begin
         if (rst_i)
         begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            pending <= '0;
         end
         else
         begin
            if (enq[c])
               wr_ptr <= wr_ptr + 1'b1;
            if (deq[c])
               rd_ptr <= rd_ptr + 1'b1;
            count <= count + CREDIT_WIDTH'(enq[c]) - CREDIT_WIDTH'(deq[c]);
            // a dequeue in the send cycle starts the next batch
            if (credit_sent_i)
               pending <= CREDIT_WIDTH'(deq[c]);
            else if (deq[c])
               pending <= pending + 1'b1;
         end
      end
   end

   // any channel at the batch size asks for a credit word
   always_comb
   begin
      credit_req_o = 1'b0;
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         if (pending_credits_o[c] >= CREDIT_WIDTH'(CREDIT_BATCH))
            credit_req_o = 1'b1;
      end
   end

endmodule

/* logic/tunnel_tx_arbiter.sv */
// outbound round-robin channel arbiter with credit counters and credit word priority
`timescale 1ns/10ps

module tunnel_tx_arbiter
   import mc_link_pkg::*;
   import fsb_tunnel_pkg::*;
(
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic [NUM_CHAN-1:0]                   chan_v_i,
   input  tunnel_payload_u [NUM_CHAN-1:0]        chan_payload_i,
   output logic [NUM_CHAN-1:0]                   chan_yumi_o,
   input  logic [NUM_CHAN-1:0][CREDIT_WIDTH-1:0] credits_returned_i,
   input  logic [NUM_CHAN-1:0][CREDIT_WIDTH-1:0] pending_credits_i,
   input  logic                                  credit_req_i,
   output logic                                  credit_sent_o,
   output logic                                  word_v_o,
   output tunnel_word_s                          word_o,
   input  logic                                  word_ready_i
);

   logic [NUM_CHAN-1:0][CREDIT_WIDTH-1:0] credits;
   logic [NUM_CHAN-1:0]                   eligible;
   logic [CHAN_IDX_WIDTH-1:0]             rr_ptr, pick;
   logic                                  pick_v;
   logic                                  data_send;

   // a channel competes only with a word and a credit in hand
   always_comb
   begin
      for (int c = 0; c < NUM_CHAN; c++)
         eligible[c] = chan_v_i[c] & (credits[c] != '0);
   end

   // search starts just after the last winner
   always_comb
   begin
      logic [CHAN_IDX_WIDTH-1:0] cand;
      pick_v = 1'b0;
      pick   = rr_ptr;
      for (int k = 1; k <= NUM_CHAN; k++)
      begin
         cand = rr_ptr + CHAN_IDX_WIDTH'(k);
         if (!pick_v && eligible[cand])
         begin
            pick_v = 1'b1;
            pick   = cand;
         end
      end
   end

   // credit word preempts data
   assign word_v_o      = credit_req_i | pick_v;
   assign credit_sent_o = credit_req_i & word_ready_i;
   assign data_send     = ~credit_req_i & pick_v & word_ready_i;

   always_comb
   begin
      if (credit_req_i)
      begin
         word_o.tag            = CREDIT_TAG;
         word_o.payload.credit = '{pad: '0, count: pending_credits_i};
      end
      else
      begin
         word_o.tag     = TAG_WIDTH'(pick);
         word_o.payload = chan_payload_i[pick];
      end
   end

   always_comb
   begin
      chan_yumi_o = '0;
      if (data_send)
         chan_yumi_o[pick] = 1'b1;
   end

   // spend and refund may land in the same cycle
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         for (int c = 0; c < NUM_CHAN; c++)
            credits[c] <= CREDIT_WIDTH'(REMOTE_CREDITS);
         // channel 0 goes first after reset
         rr_ptr <= CHAN_IDX_WIDTH'(NUM_CHAN - 1);
      end
      else
      begin
         for (int c = 0; c < NUM_CHAN; c++)
            credits[c] <= credits[c] - CREDIT_WIDTH'(chan_yumi_o[c]) + credits_returned_i[c];
         if (data_send)
            rr_ptr <= pick;
      end
   end

endmodule

/* logic/two_fifo.sv */
// two-entry register FIFO, valid/ready on the write side and valid/yumi on the read side
`timescale 1ns/10ps

module two_fifo #(
   parameter int WIDTH = 8
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             v_i,
   input  logic [WIDTH-1:0] data_i,
   output logic             ready_o,
   output logic             v_o,
   output logic [WIDTH-1:0] data_o,
   input  logic             yumi_i
);

   logic [1:0][WIDTH-1:0] mem;
   logic                  head, tail;
   logic                  full, empty;
   logic                  enq, deq;

   // no enqueue while full, even with a dequeue in the same cycle
   assign ready_o = ~full;
   assign v_o     = ~empty;
   assign data_o  = mem[head];
   assign enq     = v_i & ~full;
   // yumi only comes while v_o is high
   assign deq     = yumi_i;

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         mem[tail] <= data_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         head  <= 1'b0;
         tail  <= 1'b0;
         full  <= 1'b0;
         empty <= 1'b1;
      end
      else
      begin
         if (enq)
            tail <= ~tail;
         if (deq)
            head <= ~head;
         // occupancy only moves when exactly one side fires
         if (enq && !deq)
         begin
            empty <= 1'b0;
            full  <= ~empty;
         end
         else if (deq && !enq)
         begin
            full  <= 1'b0;
            empty <= ~full;
         end
      end
   end

endmodule

/* manycore_links_to_fsb.f */
logic/mc_link_pkg.sv
logic/fsb_tunnel_pkg.sv
logic/two_fifo.sv
logic/tunnel_rx_decode.sv
logic/tunnel_tx_arbiter.sv
logic/fsb_frame_out.sv
logic/manycore_links_to_fsb.sv
testbench/tb_clock_gen.sv
testbench/tb_scoreboard.sv
testbench/tb_links_to_fsb.sv

/* testbench/tb_clock_gen.sv */
// testbench clock source and synchronous reset
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int PERIOD = 40,
   parameter int RESET_CYCLES = 4
) (
   output logic clk_o,
   output logic rst_o
);

   // free running, starts low
   initial
   begin
      clk_o = 1'b0;
      forever
         #(PERIOD / 2) clk_o = ~clk_o;
   end

   // reset seen high on the first few rising edges
   initial
   begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES)
         @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

/* testbench/tb_links_to_fsb.sv */
// testbench top with stimulus table, FSB loopback, LCG throttle, watchdog and UUT
`timescale 1ns/10ps

module tb_links_to_fsb
   import mc_link_pkg::*;
   import fsb_tunnel_pkg::*;
();

   localparam int CLK_PERIOD = 40;
   localparam int NUM_ROWS = 24;
   localparam int WATCHDOG_NS = NUM_ROWS * 200 * CLK_PERIOD;
   localparam logic [31:0] LCG_SEED = 32'd45224;

   // one packet per row, fields shared by both packet kinds
   typedef struct packed {
      logic [CHAN_IDX_WIDTH-1:0] chan;
      logic [1:0]                op;
      logic [ADDR_WIDTH-1:0]     addr;
      logic [DATA_WIDTH-1:0]     data;
      logic [LOAD_ID_WIDTH-1:0]  load_id;
      logic [7:0]                cord;
      logic                      rnd_en;
      logic [NUM_CHAN-1:0]       hold;
   } row_s;

   logic                              clk, rst;
   mc_link_in_s [NUM_LINKS-1:0]       links_in;
   mc_link_out_s [NUM_LINKS-1:0]      links_out;
   logic                              fsb_v_in, fsb_ready, fsb_v_out, fsb_yumi;
   logic [RING_WIDTH-1:0]             fsb_data_in;
   fsb_frame_s                        fsb_data_out;

   logic [NUM_CHAN-1:0]               chan_v;
   mc_packet_s [NUM_LINKS-1:0]        fwd_pkt;
   mc_return_packet_s [NUM_LINKS-1:0] rev_pkt;
   logic [NUM_CHAN-1:0]               mc_ready = '1;
   logic                              throttle = 1'b1;
   logic [31:0]                       lcg_state = LCG_SEED;
   logic                              cur_rnd;
   logic [NUM_CHAN-1:0]               cur_hold;
   row_s                              rows [NUM_ROWS];
   int                                data_err, frame_err, credit_err, sb_pending;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   // ingress ready of one channel, sampled mid-cycle
   function automatic logic ingress_ready(input logic [CHAN_IDX_WIDTH-1:0] c);
      if (c[0])
         return links_out[c[1]].rev.ready_and_rev;
      else
         return links_out[c[1]].fwd.ready_and_rev;
   endfunction

   tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) clock_gen (
      .clk_o(clk),
      .rst_o(rst)
   );

   // channel 2i is link i fwd, 2i+1 is link i rev
   for (genvar i = 0; i < NUM_LINKS; i++)
   begin : g_link
      assign links_in[i].fwd = '{v: chan_v[2*i], packet: fwd_pkt[i],
                                 ready_and_rev: mc_ready[2*i]};
      assign links_in[i].rev = '{v: chan_v[2*i+1], packet: rev_pkt[i],
                                 ready_and_rev: mc_ready[2*i+1]};
   end

   // ring hop back into the same node
   // one gate on both sides so a word moves exactly once
   assign fsb_v_in    = fsb_v_out & throttle;
   assign fsb_yumi    = fsb_v_out & throttle & fsb_ready;
   assign fsb_data_in = fsb_data_out;

   manycore_links_to_fsb UUT (
      .clk_i  (clk),
      .rst_i  (rst),
      .links_i(links_in),
      .links_o(links_out),
      .v_i    (fsb_v_in),
      .data_i (fsb_data_in),
      .ready_o(fsb_ready),
      .v_o    (fsb_v_out),
      .data_o (fsb_data_out),
      .yumi_i (fsb_yumi)
   );

   tb_scoreboard scoreboard (
      .clk_i       (clk),
      .rst_i       (rst),
      .link_in_i   (links_in),
      .link_out_i  (links_out),
      .fsb_v_i     (fsb_v_out),
      .fsb_data_i  (fsb_data_out),
      .fsb_yumi_i  (fsb_yumi),
      .data_err_o  (data_err),
      .frame_err_o (frame_err),
      .credit_err_o(credit_err),
      .pending_o   (sb_pending)
   );

   // ring throttle and manycore readiness, new draw every cycle
   always @(posedge clk)
   begin
      lcg_state <= lcg_next(lcg_state);
      // about three words in four pass
      throttle <= cur_rnd ? |lcg_state[29:28] : 1'b1;
      for (int c = 0; c < NUM_CHAN; c++)
         mc_ready[c] <= cur_hold[c] ? 1'b0 : (cur_rnd ? lcg_state[24+c] : 1'b1);
   end

   task automatic load_table();
      // chan, op, addr, data, load_id, cord {src_x,src_y,dest_x,dest_y}, rnd_en, hold
      rows[0]  = '{2'd0, 2'd1, 20'h0_0100, 32'h1000_0001, 5'd1,  8'h1b, 1'b0, 4'h0};
      rows[1]  = '{2'd1, 2'd0, 20'h0_0000, 32'h2000_0002, 5'd2,  8'h24, 1'b0, 4'h0};
      rows[2]  = '{2'd2, 2'd2, 20'h0_0204, 32'h3000_0003, 5'd3,  8'h36, 1'b0, 4'h0};
      rows[3]  = '{2'd3, 2'd1, 20'h0_0000, 32'h4000_0004, 5'd4,  8'hc9, 1'b0, 4'h0};
      rows[4]  = '{2'd1, 2'd3, 20'h0_0000, 32'hdead_beef, 5'd5,  8'h5a, 1'b0, 4'h0};
      rows[5]  = '{2'd0, 2'd3, 20'hf_fffc, 32'hffff_ffff, 5'd31, 8'hff, 1'b0, 4'h0};
      // link 0 rev held back by the manycore
      rows[6]  = '{2'd1, 2'd1, 20'h0_0000, 32'h0600_0006, 5'd6,  8'h03, 1'b0, 4'h2};
      rows[7]  = '{2'd0, 2'd2, 20'h1_2340, 32'h0700_0007, 5'd7,  8'h81, 1'b0, 4'h2};
      rows[8]  = '{2'd1, 2'd2, 20'h0_0000, 32'h0800_0008, 5'd8,  8'h0e, 1'b0, 4'h2};
      rows[9]  = '{2'd2, 2'd0, 20'h5_6780, 32'h0900_0009, 5'd9,  8'h42, 1'b0, 4'h2};
      rows[10] = '{2'd1, 2'd3, 20'h0_0000, 32'h0a00_000a, 5'd10, 8'h07, 1'b0, 4'h2};
      rows[11] = '{2'd1, 2'd0, 20'h0_0000, 32'h0b00_000b, 5'd11, 8'h0c, 1'b0, 4'h2};
      rows[12] = '{2'd3, 2'd2, 20'h0_0000, 32'h0c00_000c, 5'd12, 8'h35, 1'b0, 4'h2};
      rows[13] = '{2'd1, 2'd1, 20'h0_0000, 32'h0d00_000d, 5'd13, 8'h0f, 1'b0, 4'h2};
      // random ring throttle and readiness
      rows[14] = '{2'd0, 2'd0, 20'ha_bcd0, 32'h1e00_000e, 5'd14, 8'h99, 1'b1, 4'h0};
      rows[15] = '{2'd2, 2'd1, 20'h0_0ff0, 32'h1f00_000f, 5'd15, 8'h66, 1'b1, 4'h0};
      rows[16] = '{2'd1, 2'd2, 20'h0_0000, 32'h2000_0010, 5'd16, 8'h0a, 1'b1, 4'h0};
      rows[17] = '{2'd3, 2'd3, 20'h0_0000, 32'h2100_0011, 5'd17, 8'h05, 1'b1, 4'h0};
      rows[18] = '{2'd0, 2'd2, 20'h3_3330, 32'h2200_0012, 5'd18, 8'hc3, 1'b1, 4'h0};
      rows[19] = '{2'd0, 2'd1, 20'h4_4440, 32'h2300_0013, 5'd19, 8'h3c, 1'b1, 4'h0};
      rows[20] = '{2'd3, 2'd0, 20'h0_0000, 32'h2400_0014, 5'd20, 8'h0b, 1'b1, 4'h0};
      rows[21] = '{2'd2, 2'd3, 20'h7_7770, 32'h2500_0015, 5'd21, 8'he7, 1'b1, 4'h0};
      rows[22] = '{2'd1, 2'd1, 20'h0_0000, 32'h2600_0016, 5'd22, 8'h0d, 1'b1, 4'h0};
      rows[23] = '{2'd2, 2'd0, 20'h8_8880, 32'h5a5a_a5a5, 5'd23, 8'h18, 1'b1, 4'h0};
   endtask

   // offer one row and hold it until the link FIFO takes it
   task automatic send_row(input int r);
      row_s row;
      row = rows[r];
      cur_rnd  <= row.rnd_en;
      cur_hold <= row.hold;
      if (row.chan[0])
         rev_pkt[row.chan[1]] <= '{return_type: row.op, data: row.data, load_id: row.load_id,
                                   dest_x: row.cord[3:2], dest_y: row.cord[1:0]};
      else
         fwd_pkt[row.chan[1]] <= '{op: row.op, addr: row.addr, data: row.data,
                                   load_id: row.load_id, src_x: row.cord[7:6],
                                   src_y: row.cord[5:4], dest_x: row.cord[3:2],
                                   dest_y: row.cord[1:0]};
      chan_v[row.chan] <= 1'b1;
      // ready is settled at the falling edge, transfer at the next rising edge
      @(negedge clk);
      while (!ingress_ready(row.chan))
         @(negedge clk);
      @(posedge clk);
      chan_v[row.chan] <= 1'b0;
   endtask

   task automatic report_counts();
      $display("error counts: data %0d, frame %0d, credit %0d", data_err, frame_err, credit_err);
   endtask

   initial
   begin
      chan_v   = '0;
      fwd_pkt  = '0;
      rev_pkt  = '0;
      cur_rnd  = 1'b0;
      cur_hold = '0;
      load_table();
      @(posedge clk);
      while (rst)
         @(posedge clk);
      // a few idle cycles with quiet outputs
      repeat (4)
         @(posedge clk);
      for (int r = 0; r < NUM_ROWS; r++)
         send_row(r);
      cur_rnd  <= 1'b0;
      cur_hold <= '0;
      // last packet reaches the scoreboard queue first
      repeat (2)
         @(posedge clk);
      while (sb_pending != 0)
         @(posedge clk);
      // let trailing credit frames pass
      repeat (20)
         @(posedge clk);
      report_counts();
      if (data_err + frame_err + credit_err == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   // bound on the whole run
   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout after %0d ns, %0d packets never came back", WATCHDOG_NS, sb_pending);
      report_counts();
      $display("Test FAILED");
      $finish;
   end

endmodule

/* testbench/tb_scoreboard.sv */
// scoreboard for per-channel packet order, FSB frame format, frame hold and credit bounds
`timescale 1ns/10ps

module tb_scoreboard
   import mc_link_pkg::*;
   import fsb_tunnel_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  mc_link_in_s [NUM_LINKS-1:0]  link_in_i,
   input  mc_link_out_s [NUM_LINKS-1:0] link_out_i,
   input  logic                         fsb_v_i,
   input  fsb_frame_s                   fsb_data_i,
   input  logic                         fsb_yumi_i,
   output int                           data_err_o,
   output int                           frame_err_o,
   output int                           credit_err_o,
   output int                           pending_o
);

   // expected packets per channel, return packets zero padded
   logic [PAYLOAD_WIDTH-1:0] exp_q [NUM_CHAN][$];
   int                       outstanding [NUM_CHAN];
   int                       queued;
   logic                     started;
   logic                     prev_v, prev_yumi;
   fsb_frame_s               prev_frame;
   tunnel_word_s             word;

   task automatic check_delivery(input int c, input logic [PAYLOAD_WIDTH-1:0] got,
                                 input string name);
      logic [PAYLOAD_WIDTH-1:0] exp;
      if (exp_q[c].size() == 0)
      begin
         $display("channel %0d delivered a packet that was never sent", c);
         data_err_o++;
      end
      else
      begin
         exp = exp_q[c].pop_front();
         if (got !== exp)
         begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            data_err_o++;
         end
      end
   endtask

   // sampled mid-cycle, all ports settled
   always @(negedge clk_i)
   begin
      if (rst_i)
      begin
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            exp_q[c].delete();
            outstanding[c] = 0;
         end
         started   = 1'b0;
         prev_v    = 1'b0;
         prev_yumi = 1'b0;
         pending_o = 0;
      end
      else
      begin
         // quiet outputs until the first packet goes in
         if (!started)
         begin
            if (fsb_v_i !== 1'b0)
            begin
               $display("[ERROR] v_o got %h expected 0", fsb_v_i);
               frame_err_o++;
            end
            for (int i = 0; i < NUM_LINKS; i++)
            begin
               if (link_out_i[i].fwd.v !== 1'b0 || link_out_i[i].rev.v !== 1'b0)
               begin
                  $display("[ERROR] links_o[%0d] fwd.v/rev.v got %h/%h expected 0/0", i,
                           link_out_i[i].fwd.v, link_out_i[i].rev.v);
                  data_err_o++;
               end
            end
         end

         // deliveries toward the manycore
         for (int i = 0; i < NUM_LINKS; i++)
         begin
            if (link_out_i[i].fwd.v && link_in_i[i].fwd.ready_and_rev)
               check_delivery(2*i, link_out_i[i].fwd.packet,
                              $sformatf("links_o[%0d].fwd.packet", i));
            if (link_out_i[i].rev.v && link_in_i[i].rev.ready_and_rev)
               check_delivery(2*i+1, PAYLOAD_WIDTH'(link_out_i[i].rev.packet),
                              $sformatf("links_o[%0d].rev.packet", i));
         end

         // packets taken from the manycore
         for (int i = 0; i < NUM_LINKS; i++)
         begin
            if (link_in_i[i].fwd.v && link_out_i[i].fwd.ready_and_rev)
            begin
               exp_q[2*i].push_back(link_in_i[i].fwd.packet);
               started = 1'b1;
            end
            if (link_in_i[i].rev.v && link_out_i[i].rev.ready_and_rev)
            begin
               exp_q[2*i+1].push_back(PAYLOAD_WIDTH'(link_in_i[i].rev.packet));
               started = 1'b1;
            end
         end

         // frame format
         word = fsb_data_i.data[$bits(tunnel_word_s)-1:0];
         if (fsb_v_i)
         begin
            if (fsb_data_i.destid !== DEST_ID)
            begin
               $display("[ERROR] data_o.destid got %h expected %h", fsb_data_i.destid, DEST_ID);
               frame_err_o++;
            end
            if (fsb_data_i.cmd !== 1'b0)
            begin
               $display("[ERROR] data_o.cmd got %h expected 0", fsb_data_i.cmd);
               frame_err_o++;
            end
            if (word.tag > CREDIT_TAG)
            begin
               $display("[ERROR] data_o tag got %h expected 0 to %h", word.tag, CREDIT_TAG);
               frame_err_o++;
            end
         end

         // a waiting frame holds still
         if (prev_v && !prev_yumi)
         begin
            if (!fsb_v_i)
            begin
               $display("v_o fell while its frame was still waiting for yumi_i");
               frame_err_o++;
            end
            else if (fsb_data_i !== prev_frame)
            begin
               $display("[ERROR] data_o got %h expected %h", fsb_data_i, prev_frame);
               frame_err_o++;
            end
         end

         // data frames in flight minus credits handed back
         if (fsb_v_i && fsb_yumi_i)
         begin
            if (word.tag == CREDIT_TAG)
            begin
               for (int c = 0; c < NUM_CHAN; c++)
               begin
                  outstanding[c] = outstanding[c] - int'(word.payload.credit.count[c]);
                  if (outstanding[c] < 0)
                  begin
                     $display("channel %0d got back more credits than frames it sent", c);
                     credit_err_o++;
                  end
               end
            end
            else if (word.tag < TAG_WIDTH'(NUM_CHAN))
            begin
               outstanding[int'(word.tag)]++;
               if (outstanding[int'(word.tag)] > REMOTE_CREDITS)
               begin
                  $display("[ERROR] chan%0d outstanding frames got %h limit %h", word.tag,
                           outstanding[int'(word.tag)], REMOTE_CREDITS);
                  credit_err_o++;
               end
            end
         end

         prev_v     = fsb_v_i;
         prev_yumi  = fsb_yumi_i;
         prev_frame = fsb_data_i;

         queued = 0;
         for (int c = 0; c < NUM_CHAN; c++)
            queued = queued + exp_q[c].size();
         pending_o = queued;
      end
   end

endmodule
